// ==== verif/vmem_stage_stimulus.txt ====
# name instr rs1 rs2 vst0 vst1 vst2 vst3 mask paddr pword accesses word wen lane0-3 mal ill
# all hex; paddr fff means no preload, memory otherwise holds a5000000 or byte address
lb_off0 00010283 40 0 0 0 0 0 0 40 80f17f92 1 ffffff92 0 0 0 0 0 0 0
lbu_off3 00314303 40 0 0 0 0 0 0 fff 0 1 00000080 0 0 0 0 0 0 0
lh_off2 00211403 40 0 0 0 0 0 0 fff 0 1 ffff80f1 0 0 0 0 0 0 0
lhu_off0 00015483 40 0 0 0 0 0 0 fff 0 1 00007f92 0 0 0 0 0 0 0
lw_negimm ffc12583 44 0 0 0 0 0 0 fff 0 1 80f17f92 0 0 0 0 0 0 0
sb_off1 003100a3 80 cafebabe 0 0 0 0 0 80 11223344 1 0 0 0 0 0 0 0 0
sh_off2 00311123 80 5555aaaa 0 0 0 0 0 fff 0 1 0 0 0 0 0 0 0 0
lw_after_st 00012603 80 0 0 0 0 0 0 fff 0 1 aaaabe44 0 0 0 0 0 0 0
vle_unmasked 02016087 100 0 0 0 0 0 0 fff 0 4 0 f a5000100 a5000104 a5000108 a500010c 0 0
vle_mask_a 00016107 140 0 0 0 0 0 a fff 0 2 0 a 0 a5000144 0 a500014c 0 0
vle_mask_0 00016107 180 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0 0 0
vse_mask_5 00016227 200 0 11111111 22222222 33333333 44444444 5 fff 0 2 0 0 0 0 0 0 0 0
lw_vse_l1 00412703 200 0 0 0 0 0 0 fff 0 1 a5000204 0 0 0 0 0 0 0
lw_vse_l2 00812703 200 0 0 0 0 0 0 fff 0 1 33333333 0 0 0 0 0 0 0
vse_unmasked 02016227 240 0 aaaa0000 aaaa0001 aaaa0002 aaaa0003 0 fff 0 4 0 0 0 0 0 0 0 0
vle_readback 02016187 240 0 0 0 0 0 0 fff 0 4 0 f aaaa0000 aaaa0001 aaaa0002 aaaa0003 0 0
lh_mis 00111403 40 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0 1 0
sw_mis 00312123 80 12345678 0 0 0 0 0 fff 0 0 0 0 0 0 0 0 1 0
lw_after_mis 00012603 80 0 0 0 0 0 0 fff 0 1 aaaabe44 0 0 0 0 0 0 0
ill_add 002081b3 0 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0 0 1
ill_vstride 0a016087 100 0 0 0 0 0 0 fff 0 0 0 0 0 0 0 0 0 1

// ==== verilog.f ====
hw/rv32_instr_pkg.sv
hw/mem_access_pkg.sv
hw/mem_instr_decode.sv
hw/mem_serializer.sv
hw/load_store_controller.sv
hw/mem_writeback.sv
hw/vmem_stage_top.sv
verif/vmem_stage_tb.sv

// ==== verif/vmem_stage_tb.sv ====
// Testbench for vmem_stage_top with NUM_LANES fixed at 4 to match the stimulus columns
// Run from the project root so the stimulus file path resolves
`timescale 1ns/1ps

module vmem_stage_tb;

    import mem_access_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int TIMEOUT   = 200;

    logic                       CLK = 1'b0;
    logic                       reset;
    logic                       instr_valid;
    rv32_instr_pkg::mem_instr_u instr;
    word_t                      rs1_data;
    word_t                      rs2_data;
    word_t [NUM_LANES-1:0]      vstore_data;
    logic [NUM_LANES-1:0]       vlane_mask;
    logic                       busy, done, reg_write, mal_addr, illegal_instr;
    logic [4:0]                 rd, vd;
    word_t                      reg_wdata;
    logic [NUM_LANES-1:0]       vlane_wen;
    word_t [NUM_LANES-1:0]      vlane_wdata;
    logic                       dren, dwen;
    word_t                      daddr, dwdata;
    logic [3:0]                 dbyte_en;
    logic                       dbusy = 1'b1;
    word_t                      drdata = '0;

    // 1 KB data memory and wait state source
    word_t       mem [256];
    logic [31:0] lfsr = 32'h3205;
    logic        armed;
    int          wait_left;
    int          bus_accesses;
    int          word_errors = 0;
    int          lane_errors = 0;
    int          flag_errors = 0;
    int          other_errors = 0;
    logic        timed_out = 1'b0;

    // One stimulus line
    string                 name;
    word_t                 t_instr, t_rs1, t_rs2, t_paddr, t_pword, t_acc, t_word;
    word_t [NUM_LANES-1:0] t_vst, t_lanes;
    logic [NUM_LANES-1:0]  t_mask, t_wen;
    logic                  t_mal, t_ill;

    vmem_stage_top #(.NUM_LANES(NUM_LANES)) dut_i (.*);

    always #50 CLK = ~CLK;

    function automatic word_t fill_word(input int idx);
        return 32'hA500_0000 | word_t'(idx << 2);
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic int take_bits(input int n);
        int r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = (r << 1) | lfsr[0];
        end
        return r;
    endfunction

    // Bus model with one arming cycle and then 0 to 3 extra wait states per access
    always @(posedge CLK) begin
        if (reset) begin
            dbusy <= 1'b1;
            armed = 1'b0;
        end else if ((dren || dwen) && !dbusy) begin
            for (int b = 0; b < 4; b++) begin
                if (dwen && dbyte_en[b]) begin
                    mem[daddr[9:2]][8*b +: 8] = dwdata[8*b +: 8];
                end
            end
            bus_accesses++;
            dbusy <= 1'b1;
            armed = 1'b0;
        end else if (dren || dwen) begin
            if (!armed) begin
                armed = 1'b1;
                wait_left = take_bits(2);
            end
            if (wait_left == 0) begin
                dbusy  <= 1'b0;
                drdata <= mem[daddr[9:2]];
            end else begin
                wait_left--;
            end
        end
    end

    task automatic check_word(input string test, input string what, input word_t exp,
                              input word_t got);
        if (exp !== got) begin
            $display("Error %s %s: expected %h, actual %h", test, what, exp, got);
            word_errors++;
        end
    endtask

    task automatic check_lanes(input string test, input logic [NUM_LANES-1:0] exp_wen,
                               input word_t [NUM_LANES-1:0] exp_words,
                               input logic [NUM_LANES-1:0] got_wen,
                               input word_t [NUM_LANES-1:0] got_words);
        if (exp_wen !== got_wen) begin
            $display("Error %s lane enables: expected %b, actual %b", test, exp_wen, got_wen);
            lane_errors++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (exp_wen[l] && got_wen[l] && exp_words[l] !== got_words[l]) begin
                $display("Error %s lane %0d: expected %h, actual %h", test, l,
                         exp_words[l], got_words[l]);
                lane_errors++;
            end
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic got);
        if (exp !== got) begin
            $display("Error %s %s: expected %b, actual %b", test, what, exp, got);
            flag_errors++;
        end
    endtask

    task automatic run_test();
        word_t                 got_word = '0;
        logic [4:0]            got_rd = '0;
        word_t [NUM_LANES-1:0] got_lanes = '0;
        logic [NUM_LANES-1:0]  got_wen = '0;
        logic                  got_reg = 1'b0;
        logic                  got_done = 1'b0;
        logic                  got_mal, got_ill, got_busy;
        logic                  exp_reg;
        int                    cycles = 0;
        exp_reg = (t_instr[6:0] == 7'b0000011) && !t_mal && !t_ill;
        if (t_paddr < 1024) begin
            mem[t_paddr[9:2]] = t_pword;
        end
        bus_accesses = 0;
        @(posedge CLK);
        instr_valid <= 1'b1;
        instr       <= t_instr;
        rs1_data    <= t_rs1;
        rs2_data    <= t_rs2;
        vstore_data <= t_vst;
        vlane_mask  <= t_mask;
        // Valid stays high one more cycle with a store to 0x3f0 that must be dropped
        @(posedge CLK);
        instr    <= 32'h0031_2023;
        rs1_data <= 32'h3f0;
        rs2_data <= '1;
        @(negedge CLK);
        check_flag(name, "busy after accept", 1'b1, busy);
        @(posedge CLK);
        instr_valid <= 1'b0;
        while (!got_done && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            if (reg_write) begin
                got_reg  = 1'b1;
                got_word = reg_wdata;
                got_rd   = rd;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (vlane_wen[l]) begin
                    got_lanes[l] = vlane_wdata[l];
                end
            end
            got_wen |= vlane_wen;
            if (done) begin
                got_done = 1'b1;
                got_mal  = mal_addr;
                got_ill  = illegal_instr;
                got_busy = busy;
            end
        end
        if (!got_done) begin
            $display("Timeout: test %s saw no done within %0d cycles", name, TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            check_word(name, "bus accesses", t_acc, word_t'(bus_accesses));
            check_flag(name, "reg_write", exp_reg, got_reg);
            if (exp_reg && got_reg) begin
                check_word(name, "reg_wdata", t_word, got_word);
                check_word(name, "rd", word_t'(t_instr[11:7]), word_t'(got_rd));
            end
            check_lanes(name, t_wen, t_lanes, got_wen, got_lanes);
            if (got_wen != '0) begin
                check_word(name, "vd", word_t'(t_instr[11:7]), word_t'(vd));
            end
            check_flag(name, "mal_addr", t_mal, got_mal);
            check_flag(name, "illegal_instr", t_ill, got_ill);
            check_flag(name, "busy at done", 1'b0, got_busy);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        vstore_data = '0;
        vlane_mask  = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        repeat (10) @(posedge CLK);
        reset <= 1'b0;
        fd = $fopen("verif/vmem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/vmem_stage_stimulus.txt");
            other_errors++;
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, t_instr, t_rs1, t_rs2, t_vst[0], t_vst[1], t_vst[2], t_vst[3],
                        t_mask, t_paddr, t_pword, t_acc, t_word, t_wen,
                        t_lanes[0], t_lanes[1], t_lanes[2], t_lanes[3], t_mal, t_ill);
            if (n != 20) begin
                $display("Stimulus line could not be parsed: %s", line);
                other_errors++;
            end else begin
                run_test();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        check_word("busy_pulse", "memory at 0x3f0", fill_word(252), mem[252]);
        $display("Errors: word %0d, lane %0d, flag %0d, other %0d",
                 word_errors, lane_errors, flag_errors, other_errors);
        if (word_errors + lane_errors + flag_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/vmem_stage_top.sv ====
// Memory stage for scalar and unit-stride vector loads and stores
// NUM_LANES must be a power of two from 2 to 8
// One instruction in flight; instr_valid while busy is dropped
`timescale 1ns/1ps

module vmem_stage_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  logic                                   instr_valid,
    input  rv32_instr_pkg::mem_instr_u             instr,
    input  mem_access_pkg::word_t                  rs1_data,
    input  mem_access_pkg::word_t                  rs2_data,
    input  mem_access_pkg::word_t [NUM_LANES-1:0]  vstore_data,
    input  logic [NUM_LANES-1:0]                   vlane_mask,
    output logic                                   busy,
    output logic                                   done,
    output logic                                   reg_write,
    output logic [4:0]                             rd,
    output mem_access_pkg::word_t                  reg_wdata,
    output logic [NUM_LANES-1:0]                   vlane_wen,
    output logic [4:0]                             vd,
    output mem_access_pkg::word_t [NUM_LANES-1:0]  vlane_wdata,
    output logic                                   mal_addr,
    output logic                                   illegal_instr,
    output logic                                   dren,
    output logic                                   dwen,
    output mem_access_pkg::word_t                  daddr,
    output mem_access_pkg::word_t                  dwdata,
    output logic [3:0]                             dbyte_en,
    input  logic                                   dbusy,
    input  mem_access_pkg::word_t                  drdata
);

    import mem_access_pkg::*;

    logic                        start;
    logic                        finish;
    access_kind_t                kind;
    load_ext_t                   ext;
    word_t                       base_addr;
    word_t                       store_word;
    word_t [NUM_LANES-1:0]       vstore_words;
    logic [NUM_LANES-1:0]        lane_mask;
    logic [4:0]                  dest;
    logic                        misaligned;
    logic                        illegal;
    logic                        req_ren;
    logic                        req_wen;
    word_t                       req_addr;
    word_t                       req_wdata;
    load_ext_t                   req_ext;
    logic [$clog2(NUM_LANES)-1:0] cur_lane;
    logic                        last;
    logic                        access_done;
    word_t                       load_data;

    mem_instr_decode #(.NUM_LANES(NUM_LANES)) decode_i (
        .CLK, .reset, .instr_valid, .instr, .rs1_data, .rs2_data, .vstore_data,
        .vlane_mask, .busy, .start, .kind, .ext, .base_addr, .store_word,
        .vstore_words, .lane_mask, .dest, .misaligned, .illegal, .finish
    );

    mem_serializer #(.NUM_LANES(NUM_LANES)) serializer_i (
        .CLK, .reset, .start, .kind, .ext, .base_addr, .store_word, .vstore_words,
        .lane_mask, .misaligned, .illegal, .access_done, .req_ren, .req_wen,
        .req_addr, .req_wdata, .req_ext, .cur_lane, .last
    );

    load_store_controller lsc_i (
        .req_ren, .req_wen, .req_addr, .req_wdata, .req_ext, .dbusy, .drdata,
        .dren, .dwen, .daddr, .dwdata, .dbyte_en, .access_done, .load_data
    );

    mem_writeback #(.NUM_LANES(NUM_LANES)) writeback_i (
        .CLK, .reset, .kind, .dest, .cur_lane, .access_done, .load_data, .last,
        .misaligned, .illegal, .reg_write, .rd, .reg_wdata, .vlane_wen, .vd,
        .vlane_wdata, .done, .mal_addr, .illegal_instr, .finish
    );

endmodule

// ==== hw/mem_writeback.sv ====
// Registers load results, one vector lane per completed access
// finish is combinational and lets the decoder drop busy as done rises
`timescale 1ns/1ps

module mem_writeback #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  mem_access_pkg::access_kind_t           kind,
    input  logic [4:0]                             dest,
    input  logic [$clog2(NUM_LANES)-1:0]           cur_lane,
    input  logic                                   access_done,
    input  mem_access_pkg::word_t                  load_data,
    input  logic                                   last,
    input  logic                                   misaligned,
    input  logic                                   illegal,
    output logic                                   reg_write,
    output logic [4:0]                             rd,
    output mem_access_pkg::word_t                  reg_wdata,
    output logic [NUM_LANES-1:0]                   vlane_wen,
    output logic [4:0]                             vd,
    output mem_access_pkg::word_t [NUM_LANES-1:0]  vlane_wdata,
    output logic                                   done,
    output logic                                   mal_addr,
    output logic                                   illegal_instr,
    output logic                                   finish
);

    import mem_access_pkg::*;

    logic scalar_wb;
    logic vector_wb;

    assign scalar_wb = access_done && (kind == SCALAR_LOAD);
    assign vector_wb = access_done && (kind == VECTOR_LOAD);
    assign finish    = last;

    always_ff @(posedge CLK) begin
        if (reset) begin
            reg_write     <= 1'b0;
            vlane_wen     <= '0;
            done          <= 1'b0;
            mal_addr      <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            reg_write <= scalar_wb;
            vlane_wen <= '0;
            if (vector_wb) begin
                vlane_wen[cur_lane] <= 1'b1;
            end
            done          <= last;
            mal_addr      <= last && misaligned;
            illegal_instr <= last && illegal;
        end
    end

    // Result data
    always_ff @(posedge CLK) begin
        if (scalar_wb) begin
            rd        <= dest;
            reg_wdata <= load_data;
        end
        if (vector_wb) begin
            vd                    <= dest;
            vlane_wdata[cur_lane] <= load_data;
        end
    end

endmodule

// ==== hw/load_store_controller.sv ====
// Combinational bridge from a lane request to the data bus
// Requests are assumed aligned to their width; drdata is used only while dbusy is low
`timescale 1ns/1ps

module load_store_controller (
    input  logic                       req_ren,
    input  logic                       req_wen,
    input  mem_access_pkg::word_t      req_addr,
    input  mem_access_pkg::word_t      req_wdata,
    input  mem_access_pkg::load_ext_t  req_ext,
    input  logic                       dbusy,
    input  mem_access_pkg::word_t      drdata,
    output logic                       dren,
    output logic                       dwen,
    output mem_access_pkg::word_t      daddr,
    output mem_access_pkg::word_t      dwdata,
    output logic [3:0]                 dbyte_en,
    output logic                       access_done,
    output mem_access_pkg::word_t      load_data
);

    import mem_access_pkg::*;

    logic [4:0] shamt;
    word_t      rdata_sh;

    assign shamt = {req_addr[1:0], 3'b000};

    assign dren        = req_ren;
    assign dwen        = req_wen;
    assign daddr       = {req_addr[31:2], 2'b00};
    assign dwdata      = req_wdata << shamt;
    assign access_done = (req_ren || req_wen) && !dbusy;

    always_comb begin
        case (req_ext)
            EXT_BYTE, EXT_BYTE_U: dbyte_en = 4'b0001 << req_addr[1:0];
            EXT_HALF, EXT_HALF_U: dbyte_en = 4'b0011 << {req_addr[1], 1'b0};
            default:              dbyte_en = 4'b1111;
        endcase
    end

    // Bring the addressed bytes down to bit 0, then extend
    assign rdata_sh = drdata >> shamt;

    always_comb begin
        case (req_ext)
            EXT_BYTE:   load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            EXT_BYTE_U: load_data = {24'h0, rdata_sh[7:0]};
            EXT_HALF:   load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            EXT_HALF_U: load_data = {16'h0, rdata_sh[15:0]};
            default:    load_data = drdata;
        endcase
    end

endmodule

// ==== hw/mem_serializer.sv ====
// One bus request per enabled lane, lowest lane first
// A scalar access runs as a single step on lane 0
`timescale 1ns/1ps

module mem_serializer #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  logic                                   start,
    input  mem_access_pkg::access_kind_t           kind,
    input  mem_access_pkg::load_ext_t              ext,
    input  mem_access_pkg::word_t                  base_addr,
    input  mem_access_pkg::word_t                  store_word,
    input  mem_access_pkg::word_t [NUM_LANES-1:0]  vstore_words,
    input  logic [NUM_LANES-1:0]                   lane_mask,
    input  logic                                   misaligned,
    input  logic                                   illegal,
    input  logic                                   access_done,
    output logic                                   req_ren,
    output logic                                   req_wen,
    output mem_access_pkg::word_t                  req_addr,
    output mem_access_pkg::word_t                  req_wdata,
    output mem_access_pkg::load_ext_t              req_ext,
    output logic [$clog2(NUM_LANES)-1:0]           cur_lane,
    output logic                                   last
);

    import mem_access_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    logic [NUM_LANES-1:0] remain;
    logic [NUM_LANES-1:0] first_mask;
    logic [NUM_LANES-1:0] pend;
    logic [NUM_LANES-1:0] next_mask;
    logic                 is_vec;
    logic                 is_load;

    assign is_vec  = (kind == VECTOR_LOAD) || (kind == VECTOR_STORE);
    assign is_load = (kind == SCALAR_LOAD) || (kind == VECTOR_LOAD);

    // Lanes still to run; nothing runs for faulting or illegal accesses
    always_comb begin
        if (misaligned || illegal || kind == NONE) begin
            first_mask = '0;
        end else if (is_vec) begin
            first_mask = lane_mask;
        end else begin
            first_mask = {{(NUM_LANES-1){1'b0}}, 1'b1};
        end
    end

    assign pend = start ? first_mask : remain;

    // Lowest pending lane wins
    always_comb begin
        cur_lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pend[i]) begin
                cur_lane = LANE_W'(i);
            end
        end
    end

    assign next_mask = pend & ~(NUM_LANES'(1) << cur_lane);

    assign req_ren   = (|pend) && is_load;
    assign req_wen   = (|pend) && !is_load;
    assign req_addr  = base_addr + word_t'({cur_lane, 2'b00});
    assign req_wdata = is_vec ? vstore_words[cur_lane] : store_word;
    assign req_ext   = ext;

    assign last = (start && first_mask == '0) || (access_done && next_mask == '0);

    always_ff @(posedge CLK) begin
        if (reset) begin
            remain <= '0;
        end else if (access_done) begin
            remain <= next_mask;
        end else if (start) begin
            remain <= first_mask;
        end
    end

endmodule

// ==== hw/mem_instr_decode.sv ====
// Captures one instruction at a time and holds it until finish
// Vector accesses with vm set use all lanes, otherwise vlane_mask
// Vector base address is assumed word aligned and is not checked
`timescale 1ns/1ps

module mem_instr_decode #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  logic                                   instr_valid,
    input  rv32_instr_pkg::mem_instr_u             instr,
    input  mem_access_pkg::word_t                  rs1_data,
    input  mem_access_pkg::word_t                  rs2_data,
    input  mem_access_pkg::word_t [NUM_LANES-1:0]  vstore_data,
    input  logic [NUM_LANES-1:0]                   vlane_mask,
    output logic                                   busy,
    output logic                                   start,
    output mem_access_pkg::access_kind_t           kind,
    output mem_access_pkg::load_ext_t              ext,
    output mem_access_pkg::word_t                  base_addr,
    output mem_access_pkg::word_t                  store_word,
    output mem_access_pkg::word_t [NUM_LANES-1:0]  vstore_words,
    output logic [NUM_LANES-1:0]                   lane_mask,
    output logic [4:0]                             dest,
    output logic                                   misaligned,
    output logic                                   illegal,
    input  logic                                   finish
);

    import rv32_instr_pkg::*;
    import mem_access_pkg::*;

    logic           accept;
    word_t          imm_i;
    word_t          imm_s;
    access_kind_t   d_kind;
    load_ext_t      d_ext;
    word_t          d_addr;
    logic [4:0]     d_dest;
    logic [NUM_LANES-1:0] d_mask;
    logic           d_illegal;
    logic           d_mis;

    assign accept = instr_valid && !busy;
    assign imm_i  = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.rs2_imm_4_0};
    assign imm_s  = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.rd_imm_4_0};

    always_comb begin
        d_kind    = NONE;
        d_ext     = EXT_WORD;
        d_addr    = rs1_data;
        d_dest    = instr.s.rd_imm_4_0;
        d_mask    = vlane_mask;
        d_illegal = 1'b0;
        case (instr.s.opcode)
            LOAD, STORE: begin
                d_kind = (instr.s.opcode == LOAD) ? SCALAR_LOAD : SCALAR_STORE;
                d_addr = rs1_data + ((instr.s.opcode == LOAD) ? imm_i : imm_s);
                case (instr.s.funct3)
                    W_BYTE:   d_ext = EXT_BYTE;
                    W_HALF:   d_ext = EXT_HALF;
                    W_WORD:   d_ext = EXT_WORD;
                    W_BYTE_U: d_ext = EXT_BYTE_U;
                    W_HALF_U: d_ext = EXT_HALF_U;
                    default:  d_illegal = 1'b1;
                endcase
                // Unsigned widths exist for loads only
                if (instr.s.opcode == STORE && instr.s.funct3[2]) begin
                    d_illegal = 1'b1;
                end
            end
            LOAD_FP, STORE_FP: begin
                d_kind = (instr.v.opcode == LOAD_FP) ? VECTOR_LOAD : VECTOR_STORE;
                d_dest = instr.v.vd_vs3;
                d_mask = instr.v.vm ? '1 : vlane_mask;
                if (instr.v.width != W_VEC32 || instr.v.mop != 2'b00 || instr.v.nf != 3'b000) begin
                    d_illegal = 1'b1;
                end
            end
            default: d_illegal = 1'b1;
        endcase
        if (d_illegal) begin
            d_kind = NONE;
        end
    end

    // Alignment only matters for scalar accesses
    always_comb begin
        d_mis = 1'b0;
        if (d_kind == SCALAR_LOAD || d_kind == SCALAR_STORE) begin
            if (d_ext == EXT_HALF || d_ext == EXT_HALF_U) begin
                d_mis = d_addr[0];
            end else if (d_ext == EXT_WORD) begin
                d_mis = |d_addr[1:0];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            kind         <= d_kind;
            ext          <= d_ext;
            base_addr    <= d_addr;
            store_word   <= rs2_data;
            vstore_words <= vstore_data;
            lane_mask    <= d_mask;
            dest         <= d_dest;
            misaligned   <= d_mis;
            illegal      <= d_illegal;
        end
    end

endmodule

// ==== hw/mem_access_pkg.sv ====
// Access kinds and data types passed between decode, bus control and writeback
// Load extension codes also select the store byte lanes
package mem_access_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        NONE,
        SCALAR_LOAD,
        SCALAR_STORE,
        VECTOR_LOAD,
        VECTOR_STORE
    } access_kind_t;

    typedef enum logic [2:0] {
        EXT_BYTE,
        EXT_BYTE_U,
        EXT_HALF,
        EXT_HALF_U,
        EXT_WORD
    } load_ext_t;

endpackage

// ==== hw/rv32_instr_pkg.sv ====
// RV32 load/store and vector unit-stride encodings
// Only the opcodes and width codes that the memory stage handles are named
package rv32_instr_pkg;

    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        LOAD_FP  = 7'b0000111,
        STORE_FP = 7'b0100111
    } opcode_t;

    // funct3 width field where code 6 selects 32-bit vector elements
    typedef enum logic [2:0] {
        W_BYTE   = 3'b000,
        W_HALF   = 3'b001,
        W_WORD   = 3'b010,
        W_BYTE_U = 3'b100,
        W_HALF_U = 3'b101,
        W_VEC32  = 3'b110
    } width_t;

    // I and S formats share everything but the placement of imm[4:0]
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2_imm_4_0;
        logic [4:0] rs1;
        width_t     funct3;
        logic [4:0] rd_imm_4_0;
        opcode_t    opcode;
    } scalar_ls_t;

    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] lumop_rs2;
        logic [4:0] rs1;
        width_t     width;
        logic [4:0] vd_vs3;
        opcode_t    opcode;
    } vector_ls_t;

    typedef union packed {
        scalar_ls_t s;
        vector_ls_t v;
    } mem_instr_u;

endpackage
